/* common/dcache_cfg.svh */
// ----------------------------------------------------------
// Width and geometry settings of the direct-mapped data cache
// Included by the package and by modules slicing addresses
// ----------------------------------------------------------
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// Core address and data word widths
`define DC_ADDR_W 32
`define DC_DATA_W 32

// Line size as log2 of bytes, 16-byte lines of four words
`define DC_BLOCK_W 4

// Number of lines as log2, 16 lines
`define DC_SET_W 4

// Tag is everything above the index
`define DC_TAG_W (`DC_ADDR_W - `DC_BLOCK_W - `DC_SET_W)

`endif

/* common/dcache_pkg.sv */
// ----------------------------------------------------------
// Shared types of the data cache
// Imported by every cache module
// ----------------------------------------------------------
`default_nettype none

`include "dcache_cfg.svh"

package dcache_pkg;

  // Meaningful widths of the cache
  typedef logic [`DC_ADDR_W-1:0]    addr_t;
  typedef logic [`DC_DATA_W-1:0]    data_t;
  typedef logic [`DC_TAG_W-1:0]     tag_t;
  typedef logic [`DC_SET_W-1:0]     index_t;
  typedef logic [`DC_BLOCK_W-3:0]   woff_t;
  typedef logic [`DC_DATA_W/8-1:0]  bsel_t;

  // Controller states
  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    REFILL,
    RELOOK,
    WRITE
  } dc_state_e;

endpackage

`default_nettype wire

/* hw/dcache/dcache_data_store.sv */
// ----------------------------------------------------------
// Data word memory of the cache
// Byte-enabled write port and a registered read port
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dcache_data_store
  import dcache_pkg::*;
(
  input  wire logic  clk,
  input  wire logic [$bits(index_t)+$bits(woff_t)-1:0] rd_adr_i,
  input  wire logic [$bits(index_t)+$bits(woff_t)-1:0] wr_adr_i,
  input  wire logic  we_i,
  input  wire data_t wr_dat_i,
  input  wire bsel_t bsel_i,
  output data_t      rd_dat_o
);

  // One word per index and word offset
  localparam int WORDS = 2 ** ($bits(index_t) + $bits(woff_t));

  data_t mem [WORDS];

  // Only selected bytes change, the rest keep the stored word
  always_ff @(posedge clk) begin
    if (we_i) begin
      for (int b = 0; b < $bits(bsel_t); b++) begin
        if (bsel_i[b]) begin
          mem[wr_adr_i][8*b +: 8] <= wr_dat_i[8*b +: 8];
        end
      end
    end
  end

  // Read word lands one cycle after its address
  always_ff @(posedge clk) begin
    rd_dat_o <= mem[rd_adr_i];
  end

endmodule

`default_nettype wire

/* hw/dcache/dcache_tag_store.sv */
// ----------------------------------------------------------
// Tag memory with valid bits and a two-way write arbiter
// Controller writes win, invalidates wait for a grant
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dcache_tag_store
  import dcache_pkg::*;
(
  input  wire logic    clk,
  input  wire logic    rst,
  input  wire index_t  rd_idx_i,
  output tag_t         rd_tag_o,
  output logic         rd_valid_o,
  input  wire logic    ctl_wr_i,
  input  wire index_t  ctl_idx_i,
  input  wire tag_t    ctl_tag_i,
  input  wire logic    ctl_valid_i,
  input  wire logic    inv_req_i,
  input  wire index_t  inv_idx_i,
  output logic         inv_gnt_o
);

  localparam int LINES = 2 ** $bits(index_t);

  tag_t             tag_mem [LINES];
  logic [LINES-1:0] valid_q;
  logic             wr_en;
  index_t           wr_idx;
  logic             wr_valid;

  // Controller first, the invalidate only clears the valid bit
  always_comb begin
    inv_gnt_o = inv_req_i && !ctl_wr_i;
    wr_en     = ctl_wr_i || inv_gnt_o;
    wr_idx    = ctl_wr_i ? ctl_idx_i : inv_idx_i;
    wr_valid  = ctl_wr_i && ctl_valid_i;
  end

  // Tag array, read result forwards a same-cycle write
  always_ff @(posedge clk) begin
    if (ctl_wr_i) begin
      tag_mem[ctl_idx_i] <= ctl_tag_i;
    end
    rd_tag_o <= (ctl_wr_i && (ctl_idx_i == rd_idx_i)) ? ctl_tag_i : tag_mem[rd_idx_i];
  end

  // Valid bits start cleared
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q    <= '0;
      rd_valid_o <= 1'b0;
    end else begin
      if (wr_en) begin
        valid_q[wr_idx] <= wr_valid;
      end
      rd_valid_o <= (wr_en && (wr_idx == rd_idx_i)) ? wr_valid : valid_q[rd_idx_i];
    end
  end

  // A granted invalidate leaves its line invalid in the next cycle
  a_inv_clears: assert property (@(posedge clk) disable iff (rst)
    inv_gnt_o |=> !valid_q[$past(inv_idx_i)]);

endmodule

`default_nettype wire

/* hw/dcache/dcache_inval.sv */
// ----------------------------------------------------------
// Invalidate request unit
// Holds one line invalidate until the tag store grants it
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "dcache_cfg.svh"

module dcache_inval
  import dcache_pkg::*;
(
  input  wire logic   clk,
  input  wire logic   rst,
  input  wire logic   inval_i,
  input  wire addr_t  inval_adr_i,
  output logic        inval_ack_o,
  output logic        inv_req_o,
  output index_t      inv_idx_o,
  input  wire logic   inv_gnt_i
);

  logic   pend_q;
  index_t idx_q;

  // A fresh strobe asks at once, a refused one is held
  assign inv_req_o = inval_i || pend_q;
  assign inv_idx_o = pend_q ? idx_q : inval_adr_i[`DC_BLOCK_W +: `DC_SET_W];

  always_ff @(posedge clk) begin
    if (rst) begin
      pend_q      <= 1'b0;
      inval_ack_o <= 1'b0;
    end else begin
      pend_q      <= inv_req_o && !inv_gnt_i;
      // Entry is clear once granted, ack in the next cycle
      inval_ack_o <= inv_req_o && inv_gnt_i;
    end
  end

  always_ff @(posedge clk) begin
    if (inval_i) begin
      idx_q <= inval_adr_i[`DC_BLOCK_W +: `DC_SET_W];
    end
  end

  a_one_inval: assert property (@(posedge clk) disable iff (rst)
    pend_q |-> !inval_i);

endmodule

`default_nettype wire

/* hw/dcache/dcache_ctrl.sv */
// ----------------------------------------------------------
// Cache controller FSM
// Handles lookup, line refill, re-lookup and write hits
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "dcache_cfg.svh"

module dcache_ctrl
  import dcache_pkg::*;
(
  input  wire logic   clk,
  input  wire logic   rst,
  input  wire logic   req_i,
  input  wire logic   we_i,
  input  wire addr_t  adr_i,
  input  wire data_t  dat_i,
  input  wire bsel_t  bsel_i,
  output logic        ack_o,
  output data_t       dat_o,
  output logic        refill_req_o,
  output addr_t       refill_adr_o,
  input  wire logic   fill_we_i,
  input  wire data_t  fill_dat_i,
  output index_t      tag_rd_idx_o,
  input  wire tag_t   tag_rd_tag_i,
  input  wire logic   tag_rd_valid_i,
  output logic        tag_wr_o,
  output index_t      tag_wr_idx_o,
  output tag_t        tag_wr_tag_o,
  output logic        tag_wr_valid_o,
  output logic [$bits(index_t)+$bits(woff_t)-1:0] dat_rd_adr_o,
  output logic [$bits(index_t)+$bits(woff_t)-1:0] dat_wr_adr_o,
  output logic        dat_we_o,
  output data_t       dat_wr_o,
  output bsel_t       dat_bsel_o,
  input  wire data_t  dat_rd_i
);

  dc_state_e state_q;
  // Latched request
  addr_t     adr_q;
  data_t     dat_q;
  bsel_t     bsel_q;
  // Next fill word of the line
  woff_t     fill_cnt_q;
  addr_t     look_adr;
  logic      hit;
  logic      filling;
  logic      last_fill;

  // Idle reads come straight from the core, re-lookup from the latch
  assign look_adr     = (state_q == IDLE) ? adr_i : adr_q;
  assign tag_rd_idx_o = look_adr[`DC_BLOCK_W +: `DC_SET_W];
  assign dat_rd_adr_o = look_adr[`DC_BLOCK_W+`DC_SET_W-1:2];

  // Stored tag valid and equal to the request tag
  assign hit = tag_rd_valid_i && (tag_rd_tag_i == adr_q[`DC_ADDR_W-1 -: `DC_TAG_W]);

  assign filling   = (state_q == REFILL) && fill_we_i;
  assign last_fill = filling && (fill_cnt_q == '1);

  // Writes ack with or without a hit, reads only on a hit
  assign ack_o = ((state_q == LOOKUP) && hit) || (state_q == WRITE);
  assign dat_o = dat_rd_i;

  // Level from the missing lookup until the last fill word
  assign refill_req_o = ((state_q == LOOKUP) && !hit) || (state_q == REFILL);
  assign refill_adr_o = {adr_q[`DC_ADDR_W-1:`DC_BLOCK_W], {`DC_BLOCK_W{1'b0}}};

  // Tag goes invalid on the first fill word and valid on the last
  assign tag_wr_o       = filling && ((fill_cnt_q == '0) || last_fill);
  assign tag_wr_idx_o   = adr_q[`DC_BLOCK_W +: `DC_SET_W];
  assign tag_wr_tag_o   = adr_q[`DC_ADDR_W-1 -: `DC_TAG_W];
  assign tag_wr_valid_o = last_fill;

  // Fill words use a full byte select, store hits the core's select
  assign dat_we_o     = filling || ((state_q == WRITE) && hit);
  assign dat_wr_adr_o = {adr_q[`DC_BLOCK_W +: `DC_SET_W],
                         (state_q == REFILL) ? fill_cnt_q : adr_q[`DC_BLOCK_W-1:2]};
  assign dat_wr_o     = (state_q == REFILL) ? fill_dat_i : dat_q;
  assign dat_bsel_o   = (state_q == REFILL) ? '1 : bsel_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q    <= IDLE;
      fill_cnt_q <= '0;
    end else begin
      // Counter wraps back to zero after the last word
      if (filling) begin
        fill_cnt_q <= fill_cnt_q + 1'b1;
      end
      case (state_q)
        IDLE:    if (req_i) state_q <= we_i ? WRITE : LOOKUP;
        LOOKUP:  state_q <= hit ? IDLE : REFILL;
        REFILL:  if (last_fill) state_q <= RELOOK;
        // Address the stores again with the filled line
        RELOOK:  state_q <= LOOKUP;
        WRITE:   state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  // Request payload
  always_ff @(posedge clk) begin
    if ((state_q == IDLE) && req_i) begin
      adr_q  <= adr_i;
      dat_q  <= dat_i;
      bsel_q <= bsel_i;
    end
  end

  // Core keeps one request outstanding until the ack
  a_no_req_busy: assert property (@(posedge clk) disable iff (rst)
    req_i |-> state_q == IDLE);

  // Memory only strobes fill words for a requested line
  a_fill_in_refill: assert property (@(posedge clk) disable iff (rst)
    fill_we_i |-> refill_req_o);

endmodule

`default_nettype wire

/* hw/dcache/dcache_top.sv */
// ----------------------------------------------------------
// Direct-mapped data cache top level
// Connects controller, invalidate unit, tag and data stores
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dcache_top
  import dcache_pkg::*;
(
  input  wire logic   clk,
  input  wire logic   rst,
  // Core request port
  input  wire logic   req_i,
  input  wire logic   we_i,
  input  wire addr_t  adr_i,
  input  wire data_t  dat_i,
  input  wire bsel_t  bsel_i,
  output logic        ack_o,
  output data_t       dat_o,
  // Refill port to memory
  output logic        refill_req_o,
  output addr_t       refill_adr_o,
  input  wire logic   fill_we_i,
  input  wire data_t  fill_dat_i,
  // Invalidate port
  input  wire logic   inval_i,
  input  wire addr_t  inval_adr_i,
  output logic        inval_ack_o
);

  // Tag store read side
  index_t tag_rd_idx;
  tag_t   tag_rd_tag;
  logic   tag_rd_valid;
  // Controller tag write
  logic   tag_wr;
  index_t tag_wr_idx;
  tag_t   tag_wr_tag;
  logic   tag_wr_valid;
  // Invalidate request and grant
  logic   inv_req;
  index_t inv_idx;
  logic   inv_gnt;
  // Data store word addresses are index and word offset
  logic [$bits(index_t)+$bits(woff_t)-1:0] dat_rd_adr;
  logic [$bits(index_t)+$bits(woff_t)-1:0] dat_wr_adr;
  logic   dat_we;
  data_t  dat_wr;
  bsel_t  dat_bsel;
  data_t  dat_rd;

  dcache_ctrl ctrl0 (
    .clk            (clk),
    .rst            (rst),
    .req_i          (req_i),
    .we_i           (we_i),
    .adr_i          (adr_i),
    .dat_i          (dat_i),
    .bsel_i         (bsel_i),
    .ack_o          (ack_o),
    .dat_o          (dat_o),
    .refill_req_o   (refill_req_o),
    .refill_adr_o   (refill_adr_o),
    .fill_we_i      (fill_we_i),
    .fill_dat_i     (fill_dat_i),
    .tag_rd_idx_o   (tag_rd_idx),
    .tag_rd_tag_i   (tag_rd_tag),
    .tag_rd_valid_i (tag_rd_valid),
    .tag_wr_o       (tag_wr),
    .tag_wr_idx_o   (tag_wr_idx),
    .tag_wr_tag_o   (tag_wr_tag),
    .tag_wr_valid_o (tag_wr_valid),
    .dat_rd_adr_o   (dat_rd_adr),
    .dat_wr_adr_o   (dat_wr_adr),
    .dat_we_o       (dat_we),
    .dat_wr_o       (dat_wr),
    .dat_bsel_o     (dat_bsel),
    .dat_rd_i       (dat_rd)
  );

  dcache_inval inval0 (
    .clk         (clk),
    .rst         (rst),
    .inval_i     (inval_i),
    .inval_adr_i (inval_adr_i),
    .inval_ack_o (inval_ack_o),
    .inv_req_o   (inv_req),
    .inv_idx_o   (inv_idx),
    .inv_gnt_i   (inv_gnt)
  );

  dcache_tag_store tags0 (
    .clk         (clk),
    .rst         (rst),
    .rd_idx_i    (tag_rd_idx),
    .rd_tag_o    (tag_rd_tag),
    .rd_valid_o  (tag_rd_valid),
    .ctl_wr_i    (tag_wr),
    .ctl_idx_i   (tag_wr_idx),
    .ctl_tag_i   (tag_wr_tag),
    .ctl_valid_i (tag_wr_valid),
    .inv_req_i   (inv_req),
    .inv_idx_i   (inv_idx),
    .inv_gnt_o   (inv_gnt)
  );

  dcache_data_store data0 (
    .clk      (clk),
    .rd_adr_i (dat_rd_adr),
    .wr_adr_i (dat_wr_adr),
    .we_i     (dat_we),
    .wr_dat_i (dat_wr),
    .bsel_i   (dat_bsel),
    .rd_dat_o (dat_rd)
  );

endmodule

`default_nettype wire

/* verification/dcache_tb.sv */
// ----------------------------------------------------------
// Table-driven testbench of the direct-mapped data cache
// Rows of reads, writes and invalidates run against dut0
// A responder plays the backing memory during refills
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dcache_tb
  import dcache_pkg::*;
;

  localparam logic [1:0] OP_RD  = 2'd0;
  localparam logic [1:0] OP_WR  = 2'd1;
  localparam logic [1:0] OP_INV = 2'd2;
  // Longest refill is about four strobes with three idle cycles each
  localparam int TIMEOUT = 64;

  typedef struct packed {
    logic [1:0] op;
    addr_t      addr;
    data_t      data;
    bsel_t      bsel;
    data_t      exp_dat;
    logic       exp_refill;
  } row_t;

  logic  clk;
  logic  rst;
  logic  req_i;
  logic  we_i;
  addr_t adr_i;
  data_t dat_i;
  bsel_t bsel_i;
  logic  ack_o;
  data_t dat_o;
  logic  refill_req_o;
  addr_t refill_adr_o;
  logic  fill_we_i;
  data_t fill_dat_i;
  logic  inval_i;
  addr_t inval_adr_i;
  logic  inval_ack_o;

  row_t   rows [$];
  int     errors;
  int     rows_failed;
  // Refills seen by the responder, and the last line base it served
  int     refill_cnt;
  addr_t  last_refill_adr;
  integer seed;

  dcache_top dut0 (
    .clk          (clk),
    .rst          (rst),
    .req_i        (req_i),
    .we_i         (we_i),
    .adr_i        (adr_i),
    .dat_i        (dat_i),
    .bsel_i       (bsel_i),
    .ack_o        (ack_o),
    .dat_o        (dat_o),
    .refill_req_o (refill_req_o),
    .refill_adr_o (refill_adr_o),
    .fill_we_i    (fill_we_i),
    .fill_dat_i   (fill_dat_i),
    .inval_i      (inval_i),
    .inval_adr_i  (inval_adr_i),
    .inval_ack_o  (inval_ack_o)
  );

  // 4 ns clock
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Backing memory contents, word address XOR a fixed pattern
  function automatic data_t mem_word(input addr_t a);
    return {2'b00, a[31:2]} ^ 32'h5a5a_0000;
  endfunction

  // Expected word after a store under a byte select
  function automatic data_t merge(input data_t old_w, input data_t new_w, input bsel_t sel);
    data_t w;
    w = old_w;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        w[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return w;
  endfunction

  function automatic string op_name(input logic [1:0] op);
    if (op == OP_RD) begin
      return "read ";
    end else if (op == OP_WR) begin
      return "write";
    end
    return "inval";
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] t=%0t %s: got 0x%08h expected 0x%08h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic add_row(input logic [1:0] op, input addr_t addr, input data_t data,
                         input bsel_t bsel, input data_t exp_dat, input logic exp_refill);
    row_t r;
    r.op         = op;
    r.addr       = addr;
    r.data       = data;
    r.bsel       = bsel;
    r.exp_dat    = exp_dat;
    r.exp_refill = exp_refill;
    rows.push_back(r);
  endtask

  // Memory side, answers each refill with four strobes and random gaps
  initial begin
    addr_t base;
    int    gap;
    fill_we_i  = 1'b0;
    fill_dat_i = '0;
    refill_cnt = 0;
    last_refill_adr = '0;
    forever begin
      @(posedge clk);
      #1;
      if (refill_req_o && !rst) begin
        refill_cnt++;
        base = refill_adr_o;
        last_refill_adr = base;
        // First cycle of the request is the missing lookup, strobes start after it
        @(posedge clk);
        #1;
        for (int k = 0; k < 4; k++) begin
          gap = $unsigned($random(seed)) % 4;
          fill_we_i = 1'b0;
          repeat (gap) begin
            @(posedge clk);
            #1;
          end
          fill_we_i  = 1'b1;
          fill_dat_i = mem_word(base + addr_t'(4 * k));
          @(posedge clk);
          #1;
        end
        fill_we_i = 1'b0;
      end
    end
  end

  task automatic run_row(input int num, input row_t r);
    int cycles;
    int refills_before;
    int errs_before;
    errs_before    = errors;
    refills_before = refill_cnt;
    @(posedge clk);
    #1;
    if (r.op == OP_INV) begin
      inval_i     = 1'b1;
      inval_adr_i = r.addr;
    end else begin
      req_i  = 1'b1;
      we_i   = (r.op == OP_WR);
      adr_i  = r.addr;
      dat_i  = r.data;
      bsel_i = r.bsel;
    end
    @(posedge clk);
    #1;
    req_i   = 1'b0;
    inval_i = 1'b0;
    cycles  = 0;
    if (r.op == OP_INV) begin
      while (!inval_ack_o && cycles < TIMEOUT) begin
        @(posedge clk);
        #1;
        cycles++;
      end
      if (!inval_ack_o) begin
        $display("row %0d: invalidate got no acknowledge within %0d cycles", num, TIMEOUT);
        errors++;
      end
    end else begin
      while (!ack_o && cycles < TIMEOUT) begin
        @(posedge clk);
        #1;
        cycles++;
      end
      if (!ack_o) begin
        $display("row %0d: request got no acknowledge within %0d cycles", num, TIMEOUT);
        errors++;
      end else if (r.op == OP_RD) begin
        check_val("dat_o", dat_o, r.exp_dat);
      end
    end
    check_val("refill count", 32'(refill_cnt - refills_before), r.exp_refill ? 32'd1 : 32'd0);
    // Refill must ask for the base of the requested line
    if (r.exp_refill && refill_cnt != refills_before) begin
      check_val("refill_adr_o", last_refill_adr, {r.addr[31:4], 4'h0});
    end
    if (errors == errs_before) begin
      $display("row %0d %s 0x%08h: ok", num, op_name(r.op), r.addr);
    end else begin
      $display("row %0d %s 0x%08h: FAIL", num, op_name(r.op), r.addr);
      rows_failed++;
    end
  endtask

  initial begin
    seed        = 32'h899c_6458;
    errors      = 0;
    rows_failed = 0;
    rst         = 1'b1;
    req_i       = 1'b0;
    we_i        = 1'b0;
    adr_i       = '0;
    dat_i       = '0;
    bsel_i      = '0;
    inval_i     = 1'b0;
    inval_adr_i = '0;

    // Cold line at index 3, then a second word of it
    add_row(OP_RD, 32'h0000_1234, '0, 4'h0, mem_word(32'h0000_1234), 1'b1);
    add_row(OP_RD, 32'h0000_1238, '0, 4'h0, mem_word(32'h0000_1238), 1'b0);
    // Partial store hit, bytes 0 and 2
    add_row(OP_WR, 32'h0000_1238, 32'hdead_beef, 4'b0101, '0, 1'b0);
    add_row(OP_RD, 32'h0000_1238, '0, 4'h0,
            merge(mem_word(32'h0000_1238), 32'hdead_beef, 4'b0101), 1'b0);
    // Store miss on a resident index leaves that line untouched
    add_row(OP_WR, 32'h0000_5638, 32'h5566_7788, 4'hf, '0, 1'b0);
    add_row(OP_RD, 32'h0000_1238, '0, 4'h0,
            merge(mem_word(32'h0000_1238), 32'hdead_beef, 4'b0101), 1'b0);
    // Store miss allocates nothing
    add_row(OP_WR, 32'h0000_2540, 32'h1122_3344, 4'hf, '0, 1'b0);
    add_row(OP_RD, 32'h0000_2540, '0, 4'h0, mem_word(32'h0000_2540), 1'b1);
    // Invalidate drops the stored word
    add_row(OP_INV, 32'h0000_1230, '0, 4'h0, '0, 1'b0);
    add_row(OP_RD, 32'h0000_1238, '0, 4'h0, mem_word(32'h0000_1238), 1'b1);
    // Same index, other tag, evicts in both directions
    add_row(OP_RD, 32'h0000_5634, '0, 4'h0, mem_word(32'h0000_5634), 1'b1);
    add_row(OP_RD, 32'h0000_1234, '0, 4'h0, mem_word(32'h0000_1234), 1'b1);
    add_row(OP_RD, 32'h0000_563c, '0, 4'h0, mem_word(32'h0000_563c), 1'b1);

    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    check_val("ack_o", {31'd0, ack_o}, 32'd0);
    check_val("refill_req_o", {31'd0, refill_req_o}, 32'd0);
    check_val("inval_ack_o", {31'd0, inval_ack_o}, 32'd0);

    for (int i = 0; i < rows.size(); i++) begin
      run_row(i, rows[i]);
    end

    $display("rows run %0d, rows failed %0d, errors %0d", rows.size(), rows_failed, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* dcache.f */
+incdir+common
common/dcache_pkg.sv
hw/dcache/dcache_data_store.sv
hw/dcache/dcache_tag_store.sv
hw/dcache/dcache_inval.sv
hw/dcache/dcache_ctrl.sv
hw/dcache/dcache_top.sv
verification/dcache_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile the data cache testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f dcache.f \
  --top-module dcache_tb \
  -Mdir obj_dir \
  && ./obj_dir/Vdcache_tb | tee /dev/stderr | grep -qx "test passed" \
  && { echo "simulation ok"; exit 0; } \
  || { echo "simulation FAILED"; exit 1; }
